//--- rtl/dcache_pkg.sv
package dcache_pkg;

    // Cache geometry, 2 ways of 128 sets with 8 half-words per block
    localparam int num_sets  = 128;
    localparam int num_words = 8;

    // Address field widths, half-word addressed so bit 0 is a byte select
    localparam int tag_w    = 5;
    localparam int index_w  = 7;
    localparam int offset_w = 3;

    // One 16-bit address word, seen raw or split into cache fields
    typedef union packed {
        logic [15:0] raw;                    // Full half-word address
        struct packed {
            logic [tag_w-1:0]    tag;        // Bits 15:11
            logic [index_w-1:0]  index;      // Bits 10:4, set select
            logic [offset_w-1:0] offset;     // Bits 3:1, word in block
            logic                byte_sel;   // Unused, always half-word access
        } fields;
    } dcache_addr_t;

endpackage

//--- rtl/fill_if.sv
`timescale 1ns/1ps

// Refill engine to datapath link
interface fill_if;
    import dcache_pkg::*;

    logic         miss;          // Lookup missed with cache enabled
    logic         busy;          // High from miss until block is in
    dcache_addr_t fill_addr;     // Block base plus word counter
    logic         wrt_data;      // One pulse per returned half-word
    logic         wrt_tag;       // Pulse with last word, sets tag and valid
    logic         read_request;  // Level to the memory side

    modport fsm (
        input  miss,
        output busy, fill_addr, wrt_data, wrt_tag, read_request
    );

    modport cache (
        output miss,
        input  busy, fill_addr, wrt_data, wrt_tag, read_request
    );

endinterface

//--- rtl/meta_array.sv
`timescale 1ns/1ps

module meta_array (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           write,    // Tag write from refill
    input  logic [dcache_pkg::index_w-1:0] index,
    input  logic [dcache_pkg::tag_w-1:0]   tag_in,
    output logic                           valid,
    output logic [dcache_pkg::tag_w-1:0]   tag_out
);
    import dcache_pkg::*;

    logic [num_sets-1:0] valid_bits;      // One per set
    logic [tag_w-1:0]    tag_mem [num_sets];

    // Valid bits must be clear after reset so nothing hits cold
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_bits <= '0;
        end else if (write) begin
            valid_bits[index] <= 1'b1;
        end
    end

    // Tag store, only meaningful where valid is set
    always_ff @(posedge clk) begin
        if (write) begin
            tag_mem[index] <= tag_in;
        end
    end

    // Lookup is combinational, same cycle as the access
    assign valid   = valid_bits[index];
    assign tag_out = tag_mem[index];

endmodule

//--- rtl/data_array.sv
`timescale 1ns/1ps

module data_array (
    input  logic                            clk,
    input  logic                            write,     // One half-word per cycle
    input  logic [dcache_pkg::index_w-1:0]  index,     // Set select
    input  logic [dcache_pkg::offset_w-1:0] offset,    // Word within block
    input  logic [15:0]                     data_in,
    output logic [15:0]                     data_out
);
    import dcache_pkg::*;

    // Block storage for one way
    logic [15:0] mem [num_sets][num_words];

    // Set and word decode folded into the array index
    always_ff @(posedge clk) begin
        if (write) begin
            mem[index][offset] <= data_in;
        end
    end

    assign data_out = mem[index][offset];  // Asynchronous read

endmodule

//--- rtl/lru_table.sv
`timescale 1ns/1ps

module lru_table (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           touch,        // Hit or fill this cycle
    input  logic                           touched_way,
    input  logic [dcache_pkg::index_w-1:0] index,
    input  logic                           valid0,
    input  logic                           valid1,
    output logic                           victim        // Way to fill on a miss
);
    import dcache_pkg::*;

    // Bit names the way to replace next in each set
    logic [num_sets-1:0] lru_bit;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lru_bit <= '0;
        end else if (touch) begin
            lru_bit[index] <= ~touched_way;  // Other way becomes least recent
        end
    end

    // Invalid ways are taken first, way 0 before way 1
    always_comb begin
        if (!valid0) begin
            victim = 1'b0;
        end else if (!valid1) begin
            victim = 1'b1;
        end else begin
            victim = lru_bit[index];
        end
    end

endmodule

//--- rtl/cache_fill_fsm.sv
`timescale 1ns/1ps

module cache_fill_fsm (
    input  logic                     clk,
    input  logic                     arst_n,
    input  dcache_pkg::dcache_addr_t miss_addr,     // CPU address of the missing access
    input  logic                     mem_data_vld,  // One pulse per half-word
    fill_if.fsm                      fill
);
    import dcache_pkg::*;

    logic                filling;       // Low is idle, high is fill
    logic [offset_w-1:0] word_cnt;      // Next word to fetch
    logic                last_word;
    logic [tag_w-1:0]    base_tag;      // Block being refilled
    logic [index_w-1:0]  base_index;

    assign last_word = (word_cnt == offset_w'(num_words - 1));

    // Control state
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            filling  <= 1'b0;
            word_cnt <= '0;
        end else if (!filling) begin
            if (fill.miss) begin
                filling  <= 1'b1;       // Busy and request rise here
                word_cnt <= '0;
            end
        end else if (mem_data_vld) begin
            word_cnt <= word_cnt + 1'b1;  // Wraps back to 0 after the last word
            if (last_word) begin
                filling <= 1'b0;        // Retry sees the block next cycle
            end
        end
    end

    // Block base captured once per miss
    always_ff @(posedge clk) begin
        if (!filling && fill.miss) begin
            base_tag   <= miss_addr.fields.tag;
            base_index <= miss_addr.fields.index;
        end
    end

    // Memory address walks the block one half-word at a time
    always_comb begin
        fill.fill_addr.fields.tag      = base_tag;
        fill.fill_addr.fields.index    = base_index;
        fill.fill_addr.fields.offset   = word_cnt;
        fill.fill_addr.fields.byte_sel = 1'b0;
    end

    assign fill.busy         = filling;
    assign fill.read_request = filling;                   // Held until the last word
    assign fill.wrt_data     = filling && mem_data_vld;   // Write each returned word
    assign fill.wrt_tag      = fill.wrt_data && last_word;  // Tag and valid with word 7

endmodule

//--- rtl/dcache.sv
`timescale 1ns/1ps

module dcache (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        wrt_en,        // Store from the CPU
    input  logic        mem_en,        // Access enable, stall when low
    input  logic        ifsm_busy,     // I-cache refill owns memory
    input  logic        mem_data_vld,  // Refill word valid
    input  logic [15:0] mem_data,
    input  logic [15:0] addr,          // CPU half-word address
    input  logic [15:0] reg_in,        // Store data
    output logic        read_req,
    output logic        fsm_busy,      // Pipeline stall on a miss
    output logic        wrt_mem,       // Write-through strobe
    output logic [15:0] cache_addr,    // Address to memory
    output logic [15:0] data_out
);
    import dcache_pkg::*;

    fill_if fill ();

    dcache_addr_t req_addr;            // CPU address, decoded
    dcache_addr_t cur_addr;            // Address the arrays see
    logic         valid0, valid1;
    logic [tag_w-1:0] tag0, tag1;
    logic [15:0]  rd0, rd1;            // Way read data
    logic         hit0, hit1, hit;
    logic         victim;              // Way picked for the refill
    logic         store_hit;
    logic         touch, touched_way;
    logic [15:0]  data_in;
    logic         wr_way0, wr_way1;
    logic         wr_meta0, wr_meta1;

    assign req_addr.raw = addr;

    // Refill address takes over while the engine is busy
    assign cur_addr.raw = fill.busy ? fill.fill_addr.raw : req_addr.raw;
    assign cache_addr   = cur_addr.raw;

    // Hit detection, valid and tag match per way
    assign hit0 = valid0 && (tag0 == cur_addr.fields.tag);
    assign hit1 = valid1 && (tag1 == cur_addr.fields.tag);
    assign hit  = hit0 || hit1;

    assign fill.miss = !hit && mem_en && !ifsm_busy;

    // Store hit writes the way and memory in the same cycle
    assign store_hit = hit && wrt_en && mem_en && !fill.busy;
    assign wrt_mem   = store_hit;

    assign data_in = fill.busy ? mem_data : reg_in;  // Refill data or store data

    // Per-way write enables
    assign wr_way0  = (store_hit && hit0) || (fill.wrt_data && !victim);
    assign wr_way1  = (store_hit && hit1) || (fill.wrt_data && victim);
    assign wr_meta0 = fill.wrt_tag && !victim;
    assign wr_meta1 = fill.wrt_tag && victim;

    // Replacement update on a hit or on the final fill word
    assign touch       = (hit && mem_en && !fill.busy) || fill.wrt_tag;
    assign touched_way = fill.busy ? victim : hit1;

    // Zero on a miss, the CPU is stalled anyway
    assign data_out = hit0 ? rd0 :
                      hit1 ? rd1 : 16'h0000;

    assign read_req = fill.read_request;
    assign fsm_busy = fill.busy;

    meta_array i_meta0 (
        .clk     (clk),
        .arst_n  (arst_n),
        .write   (wr_meta0),
        .index   (cur_addr.fields.index),
        .tag_in  (cur_addr.fields.tag),
        .valid   (valid0),
        .tag_out (tag0)
    );

    meta_array i_meta1 (
        .clk     (clk),
        .arst_n  (arst_n),
        .write   (wr_meta1),
        .index   (cur_addr.fields.index),
        .tag_in  (cur_addr.fields.tag),
        .valid   (valid1),
        .tag_out (tag1)
    );

    data_array i_data0 (
        .clk      (clk),
        .write    (wr_way0),
        .index    (cur_addr.fields.index),
        .offset   (cur_addr.fields.offset),
        .data_in  (data_in),
        .data_out (rd0)
    );

    data_array i_data1 (
        .clk      (clk),
        .write    (wr_way1),
        .index    (cur_addr.fields.index),
        .offset   (cur_addr.fields.offset),
        .data_in  (data_in),
        .data_out (rd1)
    );

    lru_table i_lru (
        .clk         (clk),
        .arst_n      (arst_n),
        .touch       (touch),
        .touched_way (touched_way),
        .index       (cur_addr.fields.index),
        .valid0      (valid0),
        .valid1      (valid1),
        .victim      (victim)
    );

    cache_fill_fsm i_fill_fsm (
        .clk          (clk),
        .arst_n       (arst_n),
        .miss_addr    (req_addr),
        .mem_data_vld (mem_data_vld),
        .fill         (fill.fsm)
    );

endmodule

//--- verification/dcache_asserts.sv
`timescale 1ns/1ps

module dcache_asserts (
    input logic        clk,
    input logic        arst_n,
    input logic        read_req,
    input logic        fsm_busy,
    input logic        wrt_mem,
    input logic        mem_data_vld,
    input logic [15:0] cache_addr,
    input logic [15:0] addr
);

    // Memory is only asked for data during a refill
    property req_needs_busy;
        @(posedge clk) disable iff (!arst_n)
            read_req |-> fsm_busy;
    endproperty

    // Write-through only from a store hit outside a refill
    property no_store_in_fill;
        @(posedge clk) disable iff (!arst_n)
            wrt_mem |-> !fsm_busy;
    endproperty

    property addr_passthrough;
        @(posedge clk) disable iff (!arst_n)
            !fsm_busy |-> (cache_addr == addr);  // CPU address goes straight out
    endproperty

    // Address held until memory answers
    property addr_held_for_memory;
        @(posedge clk) disable iff (!arst_n)
            (read_req && !mem_data_vld) |=> $stable(cache_addr);
    endproperty

    a_req_needs_busy: assert property (req_needs_busy)
        else $error("read_req is high while fsm_busy is low");
    a_no_store_in_fill: assert property (no_store_in_fill)
        else $error("wrt_mem is high during a refill");
    a_addr_passthrough: assert property (addr_passthrough)
        else $error("cache_addr differs from addr while the cache is idle");
    a_addr_held: assert property (addr_held_for_memory)
        else $error("cache_addr changed before memory answered");

endmodule

bind dcache dcache_asserts i_dcache_asserts (
    .clk          (clk),
    .arst_n       (arst_n),
    .read_req     (read_req),
    .fsm_busy     (fsm_busy),
    .wrt_mem      (wrt_mem),
    .mem_data_vld (mem_data_vld),
    .cache_addr   (cache_addr),
    .addr         (addr)
);

//--- verification/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;

    logic        clk = 1'b0;
    logic        arst_n, wrt_en, mem_en, ifsm_busy;
    logic        mem_data_vld = 1'b0;   // Owned by the memory model
    logic [15:0] mem_data = 16'h0000;
    logic [15:0] addr, reg_in;
    logic        read_req, fsm_busy, wrt_mem;
    logic [15:0] cache_addr, data_out;

    logic [15:0] mem [65536];          // Memory model behind the cache
    logic [15:0] shadow [65536];       // Expected contents kept by the stimulus
    logic [31:0] rnd_state = 32'hea36;
    int          errors = 0;
    int          timeouts = 0;

    always #50 clk = ~clk;

    dcache i_dcache (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // Start value of a memory word mixes in the full address
    function automatic logic [15:0] init_word(input logic [15:0] a);
        logic [31:0] x;
        x = xorshift(xorshift(32'hea36 ^ {a, ~a}));
        return x[15:0] ^ x[31:16];
    endfunction

    // Half-word address built from tag, set and word with byte select 0
    function automatic logic [15:0] block_addr(input logic [4:0] tag, input logic [6:0] index,
                                               input logic [2:0] offset);
        return {tag, index, offset, 1'b0};
    endfunction

    task automatic next_rand(output logic [15:0] value);
        rnd_state = xorshift(rnd_state);
        value = rnd_state[15:0];
    endtask

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        assert (actual === expected) else begin
            errors++;
            $display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    // Memory writes through on the rising edge and answers refills on the falling edge
    initial begin : memory_model
        logic [31:0] lat_state;
        int          lat;
        lat_state = 32'hea36;
        lat = -1;
        for (int i = 0; i < 65536; i++) begin
            mem[i] = init_word(16'(i));
        end
        forever begin
            @(posedge clk);
            if (wrt_mem) begin
                mem[cache_addr] = reg_in;
            end
            @(negedge clk);
            mem_data_vld = 1'b0;
            if (read_req) begin
                if (lat < 0) begin
                    lat_state = xorshift(lat_state);
                    lat = int'(lat_state[1:0]);   // 1 to 4 cycles to the sampling edge
                end
                if (lat == 0) begin
                    mem_data     = mem[cache_addr];
                    mem_data_vld = 1'b1;
                    lat = -1;
                end else begin
                    lat = lat - 1;
                end
            end else begin
                lat = -1;
            end
        end
    end

    task automatic apply_reset();
        @(negedge clk);
        arst_n = 1'b0;
        repeat (2) @(negedge clk);
        arst_n = 1'b1;
    endtask

    // One load or store held until the retried access hits
    task automatic access(input string name, input logic [15:0] a, input logic store,
                          input logic [15:0] d, input logic expect_miss);
        int cycles;
        @(negedge clk);
        addr   = a;
        reg_in = d;
        wrt_en = store;
        mem_en = 1'b1;
        @(negedge clk);                    // Lookup edge passed
        check_bit({name, " miss"}, expect_miss, fsm_busy);
        cycles = 0;
        while (fsm_busy && cycles < 200) begin
            @(negedge clk);
            cycles++;
        end
        if (fsm_busy) begin
            timeouts++;
            $display("Timeout: refill for %s did not finish within 200 cycles", name);
        end
        #25;
        check_value({name, " cache_addr"}, a, cache_addr);
        check_bit({name, " wrt_mem"}, store, wrt_mem);
        if (store) begin
            shadow[a] = d;
        end else begin
            check_value({name, " data"}, shadow[a], data_out);  // Write-through keeps memory as the reference
        end
        @(negedge clk);
        check_bit({name, " retry"}, 1'b0, fsm_busy);
        mem_en = 1'b0;
        wrt_en = 1'b0;
    endtask

    // Access that must stay quiet for three cycles
    task automatic stalled(input string name, input logic [15:0] a, input logic store,
                           input logic en, input logic ifsm);
        @(negedge clk);
        addr      = a;
        wrt_en    = store;
        mem_en    = en;
        ifsm_busy = ifsm;
        next_rand(reg_in);
        repeat (3) begin
            #25;
            if (store) begin
                check_bit({name, " wrt_mem"}, 1'b0, wrt_mem);
            end else begin
                check_bit({name, " busy"}, 1'b0, fsm_busy);
            end
            @(negedge clk);
        end
        mem_en    = 1'b0;
        wrt_en    = 1'b0;
        ifsm_busy = 1'b0;
    endtask

    initial begin
        logic [15:0] d;
        logic [15:0] r;
        arst_n    = 1'b0;
        wrt_en    = 1'b0;
        mem_en    = 1'b0;
        ifsm_busy = 1'b0;
        addr      = 16'h0000;
        reg_in    = 16'h0000;
        for (int i = 0; i < 65536; i++) begin
            shadow[i] = init_word(16'(i));
        end
        repeat (2) @(negedge clk);
        arst_n = 1'b1;
        check_bit("reset busy", 1'b0, fsm_busy);
        check_bit("reset read_req", 1'b0, read_req);

        // Cold miss followed by hits on the whole block
        access("cold_miss", block_addr(5'd3, 7'd5, 3'd2), 1'b0, 16'h0, 1'b1);
        for (int o = 0; o < 8; o++) begin
            access("block_hit", block_addr(5'd3, 7'd5, 3'(o)), 1'b0, 16'h0, 1'b0);
        end

        // Repeated hits at random words
        for (int i = 0; i < 8; i++) begin
            next_rand(r);
            access("read_hit", block_addr(5'd3, 7'd5, r[2:0]), 1'b0, 16'h0, 1'b0);
        end

        // Store hit followed by a store miss with allocate
        next_rand(d);
        access("store_hit", block_addr(5'd3, 7'd5, 3'd4), 1'b1, d, 1'b0);
        check_value("store_hit memory", d, mem[block_addr(5'd3, 7'd5, 3'd4)]);
        access("store_hit read", block_addr(5'd3, 7'd5, 3'd4), 1'b0, 16'h0, 1'b0);
        next_rand(d);
        access("store_miss", block_addr(5'd9, 7'd20, 3'd1), 1'b1, d, 1'b1);
        check_value("store_miss memory", d, mem[block_addr(5'd9, 7'd20, 3'd1)]);
        access("store_miss read", block_addr(5'd9, 7'd20, 3'd1), 1'b0, 16'h0, 1'b0);

        // A and B share set 40 and C evicts B after A is touched again
        access("lru fill A", block_addr(5'd1, 7'd40, 3'd0), 1'b0, 16'h0, 1'b1);
        access("lru fill B", block_addr(5'd2, 7'd40, 3'd3), 1'b0, 16'h0, 1'b1);
        access("lru touch A", block_addr(5'd1, 7'd40, 3'd5), 1'b0, 16'h0, 1'b0);
        access("lru fill C", block_addr(5'd3, 7'd40, 3'd7), 1'b0, 16'h0, 1'b1);
        access("lru keep A", block_addr(5'd1, 7'd40, 3'd1), 1'b0, 16'h0, 1'b0);
        access("lru lost B", block_addr(5'd2, 7'd40, 3'd3), 1'b0, 16'h0, 1'b1);

        // Stalls block misses and stores
        stalled("ifsm stall", block_addr(5'd7, 7'd60, 3'd0), 1'b0, 1'b1, 1'b1);
        stalled("mem_en low read", block_addr(5'd7, 7'd60, 3'd0), 1'b0, 1'b0, 1'b0);
        stalled("mem_en low store", block_addr(5'd3, 7'd5, 3'd4), 1'b1, 1'b0, 1'b0);
        access("after stall", block_addr(5'd3, 7'd5, 3'd4), 1'b0, 16'h0, 1'b0);
        access("stall absent", block_addr(5'd7, 7'd60, 3'd0), 1'b0, 16'h0, 1'b1);

        // Second reset drops every block
        apply_reset();
        access("reset miss", block_addr(5'd3, 7'd5, 3'd2), 1'b0, 16'h0, 1'b1);

        repeat (2) @(negedge clk);
        $display("Checks done with %0d errors and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- dcache.f
rtl/dcache_pkg.sv
rtl/fill_if.sv
rtl/meta_array.sv
rtl/data_array.sv
rtl/lru_table.sv
rtl/cache_fill_fsm.sv
rtl/dcache.sv
verification/dcache_asserts.sv
verification/tb_dcache.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_dcache -f dcache.f -o sim_dcache

# Log is searched below, exit status of the run is not trusted alone
./obj_dir/sim_dcache | tee sim.log

if ! grep -q "^Testbench passed$" sim.log; then
    echo "Simulation did not pass, see sim.log"
    exit 1
fi

echo "Simulation finished, see sim.log"
